// File: source/lc3b_types.sv
package lc3b_types;

typedef logic [15:0] lc3b_word;

// standard lc3b opcode field, instr[15:12].
typedef enum logic [3:0] {
	op_br   = 4'b0000,
	op_add  = 4'b0001,
	op_ldb  = 4'b0010,
	op_stb  = 4'b0011,
	op_jsr  = 4'b0100,
	op_and  = 4'b0101,
	op_ldr  = 4'b0110,
	op_str  = 4'b0111,
	op_rti  = 4'b1000,
	op_not  = 4'b1001,
	op_ldi  = 4'b1010,
	op_sti  = 4'b1011,
	op_jmp  = 4'b1100,
	op_shf  = 4'b1101,
	op_lea  = 4'b1110,
	op_trap = 4'b1111
} lc3b_opcode;

typedef enum logic [2:0] {
	alu_add  = 3'b000,
	alu_and  = 3'b001,
	alu_not  = 3'b010,
	alu_pass = 3'b011,
	alu_sll  = 3'b100,
	alu_srl  = 3'b101,
	alu_sra  = 3'b110
} lc3b_aluop;

typedef struct packed {
	lc3b_opcode opcode;
	lc3b_aluop  aluop;
	logic       load_regfile;
	logic       load_cc;
	logic [1:0] sr2mux_sel;     // immediate kind when sr2mux2_sel is set.
	logic       sr2mux2_sel;    // 0 picks sr2 register.
	logic       writemux_sel;   // dest forced to r7.
	logic       load_hazard;    // memory result, no writeback here.
	logic       bradd2mux_sel;
	logic       alumux_sel;     // trap vector into alu b.
	logic       alu_forward;
	logic [1:0] newpcmux_sel;
	logic [2:0] regfilemux_sel;
} lc3b_control_word;

endpackage : lc3b_types

// File: source/lc3b_stream_pkg.sv
package lc3b_stream_pkg;

// word in flight between fetch and execute.
typedef struct packed {
	lc3b_types::lc3b_word instr;
	lc3b_types::lc3b_word pc;
} queued_instr;

// one record per retired instruction.
typedef struct packed {
	lc3b_types::lc3b_word   pc;
	lc3b_types::lc3b_opcode opcode;
	logic [2:0]             dest;
	logic                   reg_write;
	lc3b_types::lc3b_word   value;
	logic [2:0]             cc;         // n z p.
} retire_rec;

endpackage : lc3b_stream_pkg

// File: source/control_rom.sv
`timescale 1ns/1ps

module control_rom (
	input  lc3b_types::lc3b_opcode       opcode,
	input  logic                         ir4,
	input  logic                         ir5,
	input  logic                         ir11,
	output lc3b_types::lc3b_control_word ctrl
);

	import lc3b_types::*;

	always_comb begin
		ctrl.opcode = opcode;
		ctrl.aluop = alu_pass;
		ctrl.load_regfile = 1'b0;
		ctrl.load_cc = 1'b0;
		ctrl.sr2mux_sel = 2'b00;
		ctrl.sr2mux2_sel = 1'b0;
		ctrl.writemux_sel = 1'b0;
		ctrl.load_hazard = 1'b0;
		ctrl.bradd2mux_sel = 1'b0;
		ctrl.alumux_sel = 1'b0;
		ctrl.alu_forward = 1'b0;
		ctrl.newpcmux_sel = 2'b00;
		ctrl.regfilemux_sel = 3'b000;

		case (opcode)
			op_add, op_and: begin
				if (ir5) begin
					ctrl.sr2mux_sel = 2'b10;    // sext imm5.
					ctrl.sr2mux2_sel = 1'b1;
				end
				ctrl.aluop = (opcode == op_add) ? alu_add : alu_and;
				ctrl.alu_forward = 1'b1;
				ctrl.load_regfile = 1'b1;
				ctrl.load_cc = 1'b1;
			end

			op_not: begin
				ctrl.aluop = alu_not;
				ctrl.alu_forward = 1'b1;
				ctrl.load_regfile = 1'b1;
				ctrl.load_cc = 1'b1;
			end

			op_shf: begin
				ctrl.sr2mux_sel = 2'b11;        // imm4 shift count.
				ctrl.sr2mux2_sel = 1'b1;
				if (!ir4)
					ctrl.aluop = alu_sll;
				else if (!ir5)
					ctrl.aluop = alu_srl;
				else
					ctrl.aluop = alu_sra;
				ctrl.alu_forward = 1'b1;
				ctrl.load_regfile = 1'b1;
				ctrl.load_cc = 1'b1;
			end

			op_lea: begin
				ctrl.regfilemux_sel = 3'b011;   // pc + 2 + off9 * 2.
				ctrl.alu_forward = 1'b1;
				ctrl.load_regfile = 1'b1;
				ctrl.load_cc = 1'b1;
			end

			op_br: begin
				ctrl.newpcmux_sel = 2'b01;
			end

			op_jmp: begin
				ctrl.bradd2mux_sel = 1'b1;      // target from base register.
			end

			op_jsr: begin
				ctrl.writemux_sel = 1'b1;
				ctrl.regfilemux_sel = 3'b010;   // link pc + 2.
				ctrl.load_regfile = 1'b1;
				if (!ir11)
					ctrl.bradd2mux_sel = 1'b1;  // jsrr form.
			end

			op_trap: begin
				ctrl.writemux_sel = 1'b1;
				ctrl.regfilemux_sel = 3'b010;
				ctrl.load_regfile = 1'b1;
				ctrl.alumux_sel = 1'b1;         // vector table address.
				ctrl.newpcmux_sel = 2'b10;
			end

			op_ldr, op_ldi: begin
				ctrl.sr2mux2_sel = 1'b1;        // word offset6.
				ctrl.aluop = alu_add;
				ctrl.regfilemux_sel = 3'b001;
				ctrl.load_hazard = 1'b1;
				ctrl.load_regfile = 1'b1;
				ctrl.load_cc = 1'b1;
			end

			op_ldb: begin
				ctrl.sr2mux_sel = 2'b01;        // byte offset6.
				ctrl.sr2mux2_sel = 1'b1;
				ctrl.aluop = alu_add;
				ctrl.regfilemux_sel = 3'b100;
				ctrl.load_hazard = 1'b1;
				ctrl.load_regfile = 1'b1;
				ctrl.load_cc = 1'b1;
			end

			op_str, op_sti: begin
				ctrl.sr2mux2_sel = 1'b1;
				ctrl.aluop = alu_add;
			end

			op_stb: begin
				ctrl.sr2mux_sel = 2'b01;
				ctrl.sr2mux2_sel = 1'b1;
				ctrl.aluop = alu_add;
			end

			default: begin
				ctrl = '0;                      // rti and anything unknown.
			end
		endcase
	end

endmodule : control_rom

// File: source/lc3b_alu.sv
`timescale 1ns/1ps

module lc3b_alu (
	input  lc3b_types::lc3b_aluop aluop,
	input  lc3b_types::lc3b_word  a,
	input  lc3b_types::lc3b_word  b,
	output lc3b_types::lc3b_word  f
);

	import lc3b_types::*;

	logic [3:0] shamt;

	assign shamt = b[3:0];                  // shifts use low nibble.

	always_comb begin
		case (aluop)
			alu_add: f = a + b;
			alu_and: f = a & b;
			alu_not: f = ~a;
			alu_sll: f = a << shamt;
			alu_srl: f = a >> shamt;
			alu_sra: f = lc3b_word'($signed(a) >>> shamt);
			default: f = b;                 // pass.
		endcase
	end

endmodule : lc3b_alu

// File: source/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit #(
	parameter int              QUEUE_DEPTH = 4,
	parameter logic [15:0]     START_PC    = 16'h3000
) (
	input  logic                         clk,
	input  logic                         rst,
	input  logic                         in_valid,
	input  lc3b_types::lc3b_word         in_instr,
	output logic                         in_ready,
	output logic                         q_push,
	output lc3b_stream_pkg::queued_instr q_data,
	input  logic                         credit_return
);

	import lc3b_types::*;

	localparam int CRED_W = $clog2(QUEUE_DEPTH + 1);

	logic [CRED_W-1:0] credits;
	lc3b_word          pc;
	logic              accept;

	// the send register drains every cycle, so only the pending push costs a credit.
	assign in_ready = !rst && (credits > CRED_W'(q_push));
	assign accept = in_valid && in_ready;

	always_ff @(posedge clk) begin
		if (rst) begin
			q_push <= 1'b0;
			pc <= START_PC;
			credits <= CRED_W'(QUEUE_DEPTH);
		end else begin
			q_push <= accept;
			if (accept)
				pc <= pc + 16'd2;
			case ({q_push, credit_return})
				2'b10: credits <= credits - 1'b1;
				2'b01: credits <= credits + 1'b1;
				default: credits <= credits;    // none or both.
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (accept)
			q_data <= '{instr: in_instr, pc: pc};
	end

	assert property (@(posedge clk) disable iff (rst) credits <= CRED_W'(QUEUE_DEPTH))
		else $error("[ERROR] credits over depth: 0x%h", credits);
	assert property (@(posedge clk) disable iff (rst) q_push |-> credits != '0)
		else $error("[ERROR] q_push without credit, credits 0x%h", credits);

endmodule : fetch_unit

// File: source/instr_queue.sv
`timescale 1ns/1ps

module instr_queue #(
	parameter int QUEUE_DEPTH = 4
) (
	input  logic                         clk,
	input  logic                         rst,
	input  logic                         push,
	input  lc3b_stream_pkg::queued_instr push_data,
	output logic                         head_valid,
	output lc3b_stream_pkg::queued_instr head,
	input  logic                         pop,
	output logic                         credit_return
);

	import lc3b_stream_pkg::*;

	localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
	localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

	queued_instr      mem [QUEUE_DEPTH];
	logic [PTR_W-1:0] wptr;
	logic [PTR_W-1:0] rptr;
	logic [CNT_W-1:0] count;

	assign head_valid = (count != '0);
	assign head = mem[rptr];                // show-ahead read.
	assign credit_return = pop;             // one credit per freed slot.

	always_ff @(posedge clk) begin
		if (rst) begin
			wptr <= '0;
			rptr <= '0;
			count <= '0;
		end else begin
			if (push)
				wptr <= (wptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : wptr + 1'b1;
			if (pop)
				rptr <= (rptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : rptr + 1'b1;
			if (push && !pop)
				count <= count + 1'b1;
			else if (pop && !push)
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (push)
			mem[wptr] <= push_data;
	end

	assert property (@(posedge clk) disable iff (rst) push |-> count != CNT_W'(QUEUE_DEPTH))
		else $error("[ERROR] push when full, count 0x%h", count);
	assert property (@(posedge clk) disable iff (rst) pop |-> count != '0)
		else $error("[ERROR] pop when empty, count 0x%h", count);

endmodule : instr_queue

// File: source/execute_unit.sv
`timescale 1ns/1ps

module execute_unit (
	input  logic                         clk,
	input  logic                         rst,
	input  logic                         head_valid,
	input  lc3b_stream_pkg::queued_instr head,
	output logic                         pop,
	output logic                         retire_valid,
	output lc3b_stream_pkg::retire_rec   retire,
	input  logic                         retire_ready
);

	import lc3b_types::*;
	import lc3b_stream_pkg::*;

	lc3b_word         regs [8];
	logic [2:0]       cc;
	lc3b_word         ir;
	lc3b_opcode       opcode;
	lc3b_control_word ctrl;
	lc3b_word         sr1, sr2;
	lc3b_word         alu_b, alu_f;
	lc3b_word         pc_plus2, result;
	logic [2:0]       dest;
	logic             reg_write, cc_write;
	logic [2:0]       new_cc;

	assign ir = head.instr;
	assign opcode = lc3b_opcode'(ir[15:12]);

	control_rom u_rom (.opcode(opcode), .ir4(ir[4]), .ir5(ir[5]), .ir11(ir[11]), .ctrl(ctrl));

	assign sr1 = regs[ir[8:6]];
	assign sr2 = regs[ir[2:0]];

	always_comb begin
		if (ctrl.alumux_sel)
			alu_b = {7'b0, ir[7:0], 1'b0};  // trap vector address.
		else if (!ctrl.sr2mux2_sel)
			alu_b = sr2;
		else begin
			case (ctrl.sr2mux_sel)
				2'b00: alu_b = {{9{ir[5]}}, ir[5:0], 1'b0};  // word offset.
				2'b01: alu_b = {{10{ir[5]}}, ir[5:0]};
				2'b10: alu_b = {{11{ir[4]}}, ir[4:0]};
				default: alu_b = {12'b0, ir[3:0]};           // shift count.
			endcase
		end
	end

	lc3b_alu u_alu (.aluop(ctrl.aluop), .a(sr1), .b(alu_b), .f(alu_f));

	assign pc_plus2 = head.pc + 16'd2;

	always_comb begin
		case (ctrl.regfilemux_sel)
			3'b010: result = pc_plus2;                                  // link.
			3'b011: result = pc_plus2 + {{6{ir[8]}}, ir[8:0], 1'b0};    // lea.
			default: result = alu_f;        // alu value or effective address.
		endcase
	end

	assign dest = ctrl.writemux_sel ? 3'd7 : ir[11:9];
	assign reg_write = ctrl.load_regfile && !ctrl.load_hazard;
	assign cc_write = ctrl.load_cc && !ctrl.load_hazard;
	assign new_cc = result[15] ? 3'b100 : ((result == '0) ? 3'b010 : 3'b001);

	// take a new word when the retire slot is free or leaving.
	assign pop = head_valid && (!retire_valid || retire_ready);

	always_ff @(posedge clk) begin
		if (rst) begin
			retire_valid <= 1'b0;
			cc <= 3'b010;
			for (int i = 0; i < 8; i++)
				regs[i] <= '0;              // all registers start at zero.
		end else begin
			if (pop)
				retire_valid <= 1'b1;
			else if (retire_ready)
				retire_valid <= 1'b0;
			if (pop && reg_write)
				regs[dest] <= result;
			if (pop && cc_write)
				cc <= new_cc;
		end
	end

	always_ff @(posedge clk) begin
		if (pop)
			retire <= '{pc: head.pc, opcode: opcode, dest: dest, reg_write: reg_write,
				value: result, cc: cc_write ? new_cc : cc};
	end

	assert property (@(posedge clk) disable iff (rst) pop |-> head_valid)
		else $error("[ERROR] pop without head_valid, head pc 0x%h", head.pc);

endmodule : execute_unit

// File: source/lc3b_core.sv
`timescale 1ns/1ps

module lc3b_core #(
	parameter int          QUEUE_DEPTH = 4,
	parameter logic [15:0] START_PC    = 16'h3000
) (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       in_valid,
	input  lc3b_types::lc3b_word       in_instr,
	output logic                       in_ready,
	output logic                       retire_valid,
	output lc3b_stream_pkg::retire_rec retire,
	input  logic                       retire_ready
);

	import lc3b_stream_pkg::*;

	logic        q_push, credit_return;
	queued_instr q_data;
	logic        head_valid, pop;
	queued_instr head;

	fetch_unit #(.QUEUE_DEPTH(QUEUE_DEPTH), .START_PC(START_PC)) u_fetch (
		.clk(clk), .rst(rst), .in_valid(in_valid), .in_instr(in_instr),
		.in_ready(in_ready), .q_push(q_push), .q_data(q_data),
		.credit_return(credit_return));

	instr_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_queue (
		.clk(clk), .rst(rst), .push(q_push), .push_data(q_data),
		.head_valid(head_valid), .head(head), .pop(pop),
		.credit_return(credit_return));

	execute_unit u_exec (
		.clk(clk), .rst(rst), .head_valid(head_valid), .head(head), .pop(pop),
		.retire_valid(retire_valid), .retire(retire), .retire_ready(retire_ready));

endmodule : lc3b_core

// File: verification/core_tb.sv
`timescale 1ns/1ps

module core_tb;

	import lc3b_types::*;
	import lc3b_stream_pkg::*;

	localparam int          QUEUE_DEPTH = 4;
	localparam logic [15:0] START_PC    = 16'h3000;
	localparam int          NUM_INSTR   = 400;
	localparam int          CLK_NS      = 40;

	logic        clk;
	logic        rst;
	logic        in_valid;
	lc3b_word    in_instr;
	logic        in_ready;
	logic        retire_valid;
	retire_rec   retire;
	logic        retire_ready;

	logic [31:0] lcg_state;
	lc3b_word    mregs [8];
	logic [2:0]  mcc;
	lc3b_word    mpc;
	retire_rec   exp_q [$];
	retire_rec   exp_rec;          // record due at the next edge.
	logic        exp_avail;
	int          in_flight;
	int          sent;
	int          retired;
	int          stall_left;
	logic        took;
	logic        saw_full;
	int          value_errs;
	int          proto_errs;

	lc3b_core #(.QUEUE_DEPTH(QUEUE_DEPTH), .START_PC(START_PC)) dut (
		.clk(clk), .rst(rst), .in_valid(in_valid), .in_instr(in_instr),
		.in_ready(in_ready), .retire_valid(retire_valid), .retire(retire),
		.retire_ready(retire_ready));

	always #(CLK_NS / 2) clk = ~clk;

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// only opcodes with a defined result here.
	function automatic lc3b_word make_instr(input logic [31:0] r);
		logic [3:0] op;
		lc3b_word   ir;
		case (r[31:28])
			4'd2, 4'd3: op = 4'h5;              // and.
			4'd4: op = 4'h9;                    // not.
			4'd5, 4'd6: op = 4'hd;              // shf.
			4'd7: op = 4'he;                    // lea.
			4'd8: op = 4'h4;                    // jsr.
			4'd9: op = 4'hf;                    // trap.
			4'd10: op = 4'h6;                   // ldr.
			4'd11: op = 4'h2;                   // ldb.
			4'd12: op = 4'ha;                   // ldi.
			4'd13: op = 4'h7;                   // str.
			4'd14: op = r[27] ? 4'h3 : 4'hb;    // stb or sti.
			default: op = 4'h1;                 // add.
		endcase
		ir = {op, r[23:12]};
		if (op == 4'h9)
			ir[5:0] = 6'h3f;
		else if (op == 4'hf)
			ir[11:8] = 4'h0;
		return ir;
	endfunction

	// isa rules applied in acceptance order.
	task automatic model_step(input lc3b_word ir);
		lc3b_word   a;
		lc3b_word   b;
		lc3b_word   val;
		logic [2:0] dr;
		logic       wr;
		logic       setcc;
		retire_rec  rec;
		a = mregs[ir[8:6]];
		b = ir[5] ? {{11{ir[4]}}, ir[4:0]} : mregs[ir[2:0]];
		dr = ir[11:9];
		wr = 1'b1;
		setcc = 1'b1;
		case (ir[15:12])
			4'h1: val = a + b;
			4'h5: val = a & b;
			4'h9: val = ~a;
			4'hd: begin
				if (!ir[4])
					val = a << ir[3:0];
				else if (!ir[5])
					val = a >> ir[3:0];
				else
					val = 16'({{16{a[15]}}, a} >> ir[3:0]);   // sign fill.
			end
			4'he: val = mpc + 16'd2 + {{6{ir[8]}}, ir[8:0], 1'b0};
			4'h4, 4'hf: begin
				val = mpc + 16'd2;
				dr = 3'd7;
				setcc = 1'b0;
			end
			4'h2, 4'h3: begin
				val = a + {{10{ir[5]}}, ir[5:0]};           // byte offset.
				wr = 1'b0;
				setcc = 1'b0;
			end
			default: begin
				val = a + {{9{ir[5]}}, ir[5:0], 1'b0};      // word offset.
				wr = 1'b0;
				setcc = 1'b0;
			end
		endcase
		if (wr)
			mregs[dr] = val;
		if (setcc)
			mcc = val[15] ? 3'b100 : ((val == 16'h0) ? 3'b010 : 3'b001);
		rec = '{pc: mpc, opcode: lc3b_opcode'(ir[15:12]), dest: dr, reg_write: wr,
			value: val, cc: mcc};
		exp_q.push_back(rec);
		mpc = mpc + 16'd2;
	endtask

	// one falling edge of stimulus and bookkeeping.
	task automatic drive_cycle();
		logic [31:0] r;
		logic        hs;
		lcg_state = lcg_next(lcg_state);
		r = lcg_state;
		if (stall_left > 0) begin
			retire_ready = 1'b0;
			stall_left--;
		end else begin
			retire_ready = (r[31:30] != 2'd0);
			if (r[28:24] == 5'd0)
				stall_left = 12 + int'(r[23:20]);  // long enough to fill the queue.
		end
		hs = retire_valid && retire_ready;
		exp_avail = 1'b0;
		if (hs && exp_q.size() > 0) begin
			exp_rec = exp_q.pop_front();
			exp_avail = 1'b1;
		end
		if (hs)
			retired++;
		if (took) begin
			in_valid = 1'b0;
			took = 1'b0;
		end
		if (!in_valid && sent < NUM_INSTR && r[19:18] != 2'b00) begin
			lcg_state = lcg_next(lcg_state);
			in_valid = 1'b1;
			in_instr = make_instr(lcg_state);
		end
		if (!in_ready)
			saw_full = 1'b1;
		if (in_valid && in_ready) begin
			model_step(in_instr);
			sent++;
			took = 1'b1;
		end
		in_flight = in_flight + int'(took) - int'(hs);
	endtask

	assert property (@(posedge clk) rst |-> !in_ready)
		else begin
			$display("[ERROR] in_ready 0x%h during reset", $sampled(in_ready));
			proto_errs++;
		end

	assert property (@(posedge clk) $fell(rst) |-> in_ready && !retire_valid)
		else begin
			$display("[ERROR] after reset in_ready 0x%h retire_valid 0x%h",
				$sampled(in_ready), $sampled(retire_valid));
			proto_errs++;
		end

	assert property (@(posedge clk) disable iff (rst) retire_valid && retire_ready |-> exp_avail)
		else begin
			$display("retire handshake with no instruction outstanding");
			proto_errs++;
		end

	assert property (@(posedge clk) disable iff (rst)
		retire_valid && retire_ready && exp_avail |-> retire.pc == exp_rec.pc)
		else begin
			$display("[ERROR] retire.pc got 0x%h expected 0x%h", $sampled(retire.pc), exp_rec.pc);
			value_errs++;
		end

	// dest, reg_write, value and cc together.
	assert property (@(posedge clk) disable iff (rst)
		retire_valid && retire_ready && exp_avail |-> retire == exp_rec)
		else begin
			$display("[ERROR] retire got 0x%h expected 0x%h", $sampled(retire), exp_rec);
			value_errs++;
		end

	assert property (@(posedge clk) disable iff (rst) in_flight <= QUEUE_DEPTH + 2)
		else begin
			$display("more words in flight than the buffer can hold: %0d", in_flight);
			proto_errs++;
		end

	assert property (@(posedge clk) disable iff (rst) in_flight < QUEUE_DEPTH |-> in_ready)
		else begin
			$display("[ERROR] in_ready 0x%h with in_flight 0x%h", $sampled(in_ready), in_flight);
			proto_errs++;
		end

	initial begin
		#((NUM_INSTR * 40 + 200) * CLK_NS);
		$display("timeout after %0d of %0d instructions retired", retired, NUM_INSTR);
		$display("Test failures found");
		$finish;
	end

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		in_valid = 1'b0;
		in_instr = '0;
		retire_ready = 1'b0;
		lcg_state = 32'ha646_9c23;
		for (int i = 0; i < 8; i++)
			mregs[i] = '0;
		mcc = 3'b010;
		mpc = START_PC;
		exp_rec = '0;
		exp_avail = 1'b0;
		in_flight = 0;
		sent = 0;
		retired = 0;
		stall_left = 0;
		took = 1'b0;
		saw_full = 1'b0;
		value_errs = 0;
		proto_errs = 0;
		repeat (10) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		while (sent < NUM_INSTR || retired < NUM_INSTR) begin
			@(negedge clk);
			drive_cycle();
		end
		@(negedge clk);
		retire_ready = 1'b1;                    // any extra record now trips a check.
		exp_avail = 1'b0;
		repeat (8) @(negedge clk);
		if (!saw_full) begin
			$display("in_ready never fell during retire stalls");
			proto_errs++;
		end
		$display("retired %0d of %0d, value errors %0d, protocol errors %0d",
			retired, NUM_INSTR, value_errs, proto_errs);
		if (value_errs == 0 && proto_errs == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule : core_tb

// File: compile.f
source/lc3b_types.sv
source/lc3b_stream_pkg.sv
source/control_rom.sv
source/lc3b_alu.sv
source/fetch_unit.sv
source/instr_queue.sv
source/execute_unit.sv
source/lc3b_core.sv
verification/core_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= core_tb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(wildcard source/*.sv verification/*.sv)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	grep -q "All tests passed!" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
